//--- hdl/upsize_pkg.sv
/*
 * Shared widths and payload types of the AXI4 write upsizer.
 * Narrow and wide data widths, lane numbering, address offsets,
 * and the AW, B and per-burst info payload structs.
 */

package upsize_pkg;

   parameter int ADDR_W   = 32;
   parameter int ID_W     = 3;
   parameter int NARROW_W = 32;
   parameter int WIDE_W   = 128;

   // Narrow lanes per wide beat and how many bits number them
   parameter int RATIO  = WIDE_W / NARROW_W;
   parameter int LANE_W = $clog2(RATIO);

   // Byte offset bits below one narrow and one wide beat
   parameter int NARROW_OFFSET = $clog2(NARROW_W / 8);
   parameter int WIDE_OFFSET   = $clog2(WIDE_W / 8);

   parameter logic [2:0] WIDE_SIZE = 3'(WIDE_OFFSET);

   typedef logic [7:0]        len_t;
   typedef logic [LANE_W-1:0] lane_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [ID_W-1:0]   id;
      len_t              len;
      logic [1:0]        burst;
   } aw_payload_t;

   typedef struct packed {
      logic [ID_W-1:0] id;
      logic [1:0]      resp;
   } b_payload_t;

   // What the W packer needs to know about each accepted burst
   typedef struct packed {
      lane_t start_lane;
      len_t  len;
   } burst_info_t;

endpackage

//--- hdl/axi_reg_slice.sv
/*
 * Single-entry valid/ready register slice.
 * Payload type is a parameter so one module serves AW and B.
 */

`timescale 1ns/1ps

module axi_reg_slice #(
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     rst_ni,

   input  logic     valid_i,
   output logic     ready_o,
   input  payload_t data_i,

   output logic     valid_o,
   input  logic     ready_i,
   output payload_t data_o
);

   logic     full_q;
   payload_t data_q;

   // Accept when empty, or when the held item leaves this cycle
   assign ready_o = ~full_q | ready_i;
   assign valid_o = full_q;
   assign data_o  = data_q;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         full_q <= 1'b0;
      end
      else if (ready_o)
      begin
         full_q <= valid_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (valid_i && ready_o)
      begin
         data_q <= data_i;
      end
   end

endmodule

//--- hdl/upsize_info_fifo.sv
/*
 * Small circular FIFO of per-burst info (start lane, narrow length).
 * Lets the address path run ahead of the write data packer.
 */

`timescale 1ns/1ps

module upsize_info_fifo
   import upsize_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic        clk_i,
   input  logic        rst_ni,

   input  logic        push_i,
   input  burst_info_t data_i,
   output logic        full_o,

   input  logic        pop_i,
   output burst_info_t data_o,
   output logic        empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   burst_info_t      mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_push;
   logic             do_pop;

   assign full_o  = (count_q == CNT_W'(DEPTH));
   assign empty_o = (count_q == '0);
   assign data_o  = mem_q[rd_ptr_q];

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (do_push)
      begin
         mem_q[wr_ptr_q] <= data_i;
      end
   end

endmodule

//--- hdl/upsize_aw_path.sv
/*
 * Write address conversion from narrow to wide bursts.
 * Recomputes length and size, and pushes burst info on each master AW.
 */

`timescale 1ns/1ps

module upsize_aw_path
   import upsize_pkg::*;
(
   input  logic              s_valid_i,
   input  aw_payload_t       s_data_i,
   output logic              s_ready_o,

   input  logic              fifo_full_i,
   output logic              fifo_push_o,
   output burst_info_t       fifo_data_o,

   output logic              m_aw_valid_o,
   output logic [ADDR_W-1:0] m_aw_addr_o,
   output logic [ID_W-1:0]   m_aw_id_o,
   output len_t              m_aw_len_o,
   output logic [2:0]        m_aw_size_o,
   output logic [1:0]        m_aw_burst_o,
   input  logic              m_aw_ready_i
);

   logic [ADDR_W-1:0]             end_addr;
   logic [ADDR_W-WIDE_OFFSET-1:0] wide_span;

   // No address goes out unless its info entry has room
   assign m_aw_valid_o = s_valid_i & ~fifo_full_i;
   assign s_ready_o    = m_aw_ready_i & ~fifo_full_i;
   assign fifo_push_o  = m_aw_valid_o & m_aw_ready_i;

   // Address of the last narrow beat in the burst
   assign end_addr  = s_data_i.addr + (ADDR_W'(s_data_i.len) << NARROW_OFFSET);
   assign wide_span = end_addr[ADDR_W-1:WIDE_OFFSET] - s_data_i.addr[ADDR_W-1:WIDE_OFFSET];

   assign m_aw_addr_o  = s_data_i.addr;
   assign m_aw_id_o    = s_data_i.id;
   assign m_aw_len_o   = len_t'(wide_span);
   assign m_aw_size_o  = WIDE_SIZE;
   assign m_aw_burst_o = s_data_i.burst;

   assign fifo_data_o.start_lane = s_data_i.addr[WIDE_OFFSET-1:NARROW_OFFSET];
   assign fifo_data_o.len        = s_data_i.len;

endmodule

//--- hdl/upsize_w_packer.sv
/*
 * Write data packer: narrow beats into wide beats.
 * FSM (idle, collect, emit middle, emit last), lane and beat counters,
 * and the wide data and strobe registers.
 */

`timescale 1ns/1ps

module upsize_w_packer
   import upsize_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_ni,

   input  burst_info_t           info_i,
   input  logic                  info_empty_i,
   output logic                  info_pop_o,

   input  logic                  s_w_valid_i,
   input  logic [NARROW_W-1:0]   s_w_data_i,
   input  logic [NARROW_W/8-1:0] s_w_strb_i,
   input  logic                  s_w_last_i,
   output logic                  s_w_ready_o,

   output logic                  m_w_valid_o,
   output logic [WIDE_W-1:0]     m_w_data_o,
   output logic [WIDE_W/8-1:0]   m_w_strb_o,
   output logic                  m_w_last_o,
   input  logic                  m_w_ready_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_COLLECT,
      ST_EMIT_MID,
      ST_EMIT_LAST
   } state_e;

   state_e state_q;
   state_e state_d;

   logic [RATIO-1:0][NARROW_W-1:0]   data_q;
   logic [RATIO-1:0][NARROW_W-1:0]   data_d;
   logic [RATIO-1:0][NARROW_W/8-1:0] strb_q;
   logic [RATIO-1:0][NARROW_W/8-1:0] strb_d;

   lane_t lane_q;
   lane_t cur_lane;
   len_t  beat_q;
   len_t  cur_beat;
   logic  new_burst;
   logic  accept;
   logic  dispatch;
   logic  is_last;

   assign m_w_valid_o = (state_q == ST_EMIT_MID) || (state_q == ST_EMIT_LAST);
   assign m_w_last_o  = (state_q == ST_EMIT_LAST);
   assign m_w_data_o  = data_q;
   assign m_w_strb_o  = strb_q;
   assign dispatch    = m_w_valid_o & m_w_ready_i;

   // The next accepted beat opens a burst from idle or right after a last beat
   assign new_burst = (state_q == ST_IDLE) || (state_q == ST_EMIT_LAST);
   assign cur_lane  = new_burst ? info_i.start_lane : lane_q;
   assign cur_beat  = new_burst ? '0 : beat_q;

   always_comb
   begin
      case (state_q)
         ST_IDLE:      s_w_ready_o = ~info_empty_i;
         ST_COLLECT:   s_w_ready_o = 1'b1;
         ST_EMIT_MID:  s_w_ready_o = m_w_ready_i;
         default:      s_w_ready_o = m_w_ready_i & ~info_empty_i;
      endcase
   end

   assign accept = s_w_valid_i & s_w_ready_o;

   // Recorded length backs up the last flag
   assign is_last    = s_w_last_i | (cur_beat == info_i.len);
   assign info_pop_o = accept & is_last;

   always_comb
   begin
      state_d = state_q;
      if (accept)
      begin
         if (is_last)
         begin
            state_d = ST_EMIT_LAST;
         end
         else if (&cur_lane)
         begin
            state_d = ST_EMIT_MID;
         end
         else
         begin
            state_d = ST_COLLECT;
         end
      end
      else if (dispatch)
      begin
         state_d = m_w_last_o ? ST_IDLE : ST_COLLECT;
      end
   end

   // A dispatched beat clears all lanes before the new narrow beat lands
   always_comb
   begin
      data_d = dispatch ? '0 : data_q;
      strb_d = dispatch ? '0 : strb_q;
      if (accept)
      begin
         data_d[cur_lane] = s_w_data_i;
         strb_d[cur_lane] = s_w_strb_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= ST_IDLE;
         lane_q  <= '0;
         beat_q  <= '0;
         data_q  <= '0;
         strb_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         data_q  <= data_d;
         strb_q  <= strb_d;
         if (accept)
         begin
            // Lane wraps to zero after the top lane
            lane_q <= cur_lane + 1'b1;
            beat_q <= cur_beat + 1'b1;
         end
      end
   end

endmodule

//--- hdl/axi_write_upsizer.sv
/*
 * AXI4 write-channel upsizer top level.
 * AW and B register slices, burst info FIFO, address path, W packer.
 */

`timescale 1ns/1ps

module axi_write_upsizer
   import upsize_pkg::*;
#(
   parameter int INFO_DEPTH = 4
) (
   input  logic                  clk_i,
   input  logic                  rst_ni,

   input  logic                  s_aw_valid_i,
   input  logic [ADDR_W-1:0]     s_aw_addr_i,
   input  logic [ID_W-1:0]       s_aw_id_i,
   input  len_t                  s_aw_len_i,
   input  logic [1:0]            s_aw_burst_i,
   output logic                  s_aw_ready_o,

   input  logic                  s_w_valid_i,
   input  logic [NARROW_W-1:0]   s_w_data_i,
   input  logic [NARROW_W/8-1:0] s_w_strb_i,
   input  logic                  s_w_last_i,
   output logic                  s_w_ready_o,

   output logic                  s_b_valid_o,
   output logic [ID_W-1:0]       s_b_id_o,
   output logic [1:0]            s_b_resp_o,
   input  logic                  s_b_ready_i,

   output logic                  m_aw_valid_o,
   output logic [ADDR_W-1:0]     m_aw_addr_o,
   output logic [ID_W-1:0]       m_aw_id_o,
   output len_t                  m_aw_len_o,
   output logic [2:0]            m_aw_size_o,
   output logic [1:0]            m_aw_burst_o,
   input  logic                  m_aw_ready_i,

   output logic                  m_w_valid_o,
   output logic [WIDE_W-1:0]     m_w_data_o,
   output logic [WIDE_W/8-1:0]   m_w_strb_o,
   output logic                  m_w_last_o,
   input  logic                  m_w_ready_i,

   input  logic                  m_b_valid_i,
   input  logic [ID_W-1:0]       m_b_id_i,
   input  logic [1:0]            m_b_resp_i,
   output logic                  m_b_ready_o
);

   aw_payload_t s_aw_payload;
   aw_payload_t aw_slice_data;
   logic        aw_slice_valid;
   logic        aw_slice_ready;

   b_payload_t  m_b_payload;
   b_payload_t  s_b_payload;

   burst_info_t push_info;
   burst_info_t head_info;
   logic        info_push;
   logic        info_pop;
   logic        info_full;
   logic        info_empty;

   assign s_aw_payload = '{addr: s_aw_addr_i, id: s_aw_id_i, len: s_aw_len_i,
                           burst: s_aw_burst_i};
   assign m_b_payload  = '{id: m_b_id_i, resp: m_b_resp_i};
   assign s_b_id_o     = s_b_payload.id;
   assign s_b_resp_o   = s_b_payload.resp;

   axi_reg_slice #(
      .payload_t ( aw_payload_t )
   ) aw_slice (
      .clk_i   ( clk_i          ),
      .rst_ni  ( rst_ni         ),
      .valid_i ( s_aw_valid_i   ),
      .ready_o ( s_aw_ready_o   ),
      .data_i  ( s_aw_payload   ),
      .valid_o ( aw_slice_valid ),
      .ready_i ( aw_slice_ready ),
      .data_o  ( aw_slice_data  )
   );

   upsize_aw_path u_aw_path (
      .s_valid_i    ( aw_slice_valid ),
      .s_data_i     ( aw_slice_data  ),
      .s_ready_o    ( aw_slice_ready ),
      .fifo_full_i  ( info_full      ),
      .fifo_push_o  ( info_push      ),
      .fifo_data_o  ( push_info      ),
      .m_aw_valid_o ( m_aw_valid_o   ),
      .m_aw_addr_o  ( m_aw_addr_o    ),
      .m_aw_id_o    ( m_aw_id_o      ),
      .m_aw_len_o   ( m_aw_len_o     ),
      .m_aw_size_o  ( m_aw_size_o    ),
      .m_aw_burst_o ( m_aw_burst_o   ),
      .m_aw_ready_i ( m_aw_ready_i   )
   );

   upsize_info_fifo #(
      .DEPTH ( INFO_DEPTH )
   ) u_info_fifo (
      .clk_i   ( clk_i      ),
      .rst_ni  ( rst_ni     ),
      .push_i  ( info_push  ),
      .data_i  ( push_info  ),
      .full_o  ( info_full  ),
      .pop_i   ( info_pop   ),
      .data_o  ( head_info  ),
      .empty_o ( info_empty )
   );

   upsize_w_packer u_w_packer (
      .clk_i        ( clk_i       ),
      .rst_ni       ( rst_ni      ),
      .info_i       ( head_info   ),
      .info_empty_i ( info_empty  ),
      .info_pop_o   ( info_pop    ),
      .s_w_valid_i  ( s_w_valid_i ),
      .s_w_data_i   ( s_w_data_i  ),
      .s_w_strb_i   ( s_w_strb_i  ),
      .s_w_last_i   ( s_w_last_i  ),
      .s_w_ready_o  ( s_w_ready_o ),
      .m_w_valid_o  ( m_w_valid_o ),
      .m_w_data_o   ( m_w_data_o  ),
      .m_w_strb_o   ( m_w_strb_o  ),
      .m_w_last_o   ( m_w_last_o  ),
      .m_w_ready_i  ( m_w_ready_i )
   );

   axi_reg_slice #(
      .payload_t ( b_payload_t )
   ) b_slice (
      .clk_i   ( clk_i       ),
      .rst_ni  ( rst_ni      ),
      .valid_i ( m_b_valid_i ),
      .ready_o ( m_b_ready_o ),
      .data_i  ( m_b_payload ),
      .valid_o ( s_b_valid_o ),
      .ready_i ( s_b_ready_i ),
      .data_o  ( s_b_payload )
   );

endmodule

//--- verif/tb_axi_write_upsizer.sv
/*
 * Testbench for the AXI4 write upsizer.
 * Reads bursts from a data file, drives slave AW and W, models the
 * master side with random ready, and checks AW, packed W beats and B.
 */

`timescale 1ns/1ps

module tb_axi_write_upsizer
   import upsize_pkg::*;
();

   localparam int INFO_DEPTH = 4;
   localparam int MAX_BURSTS = 16;
   localparam int FIELDS     = 6;
   localparam int TIMEOUT    = 1000;
   localparam int unsigned RAND_SEED = 32'hf97caf34;

   // AXI size code is log2 of the bytes in one wide beat
   localparam logic [2:0] EXP_WIDE_SIZE = 3'($clog2(WIDE_W / 8));

   // Column order in the data file
   localparam int F_ID   = 0;
   localparam int F_ADDR = 1;
   localparam int F_LEN  = 2;
   localparam int F_DATA = 3;
   localparam int F_WLEN = 4;
   localparam int F_RESP = 5;

   logic                  clk_i;
   logic                  rst_ni;
   logic                  s_aw_valid_i;
   logic [ADDR_W-1:0]     s_aw_addr_i;
   logic [ID_W-1:0]       s_aw_id_i;
   logic [7:0]            s_aw_len_i;
   logic [1:0]            s_aw_burst_i;
   logic                  s_aw_ready_o;
   logic                  s_w_valid_i;
   logic [NARROW_W-1:0]   s_w_data_i;
   logic [NARROW_W/8-1:0] s_w_strb_i;
   logic                  s_w_last_i;
   logic                  s_w_ready_o;
   logic                  s_b_valid_o;
   logic [ID_W-1:0]       s_b_id_o;
   logic [1:0]            s_b_resp_o;
   logic                  s_b_ready_i;
   logic                  m_aw_valid_o;
   logic [ADDR_W-1:0]     m_aw_addr_o;
   logic [ID_W-1:0]       m_aw_id_o;
   logic [7:0]            m_aw_len_o;
   logic [2:0]            m_aw_size_o;
   logic [1:0]            m_aw_burst_o;
   logic                  m_aw_ready_i;
   logic                  m_w_valid_o;
   logic [WIDE_W-1:0]     m_w_data_o;
   logic [WIDE_W/8-1:0]   m_w_strb_o;
   logic                  m_w_last_o;
   logic                  m_w_ready_i;
   logic                  m_b_valid_i;
   logic [ID_W-1:0]       m_b_id_i;
   logic [1:0]            m_b_resp_i;
   logic                  m_b_ready_o;

   logic [31:0]         vec_mem [FIELDS*MAX_BURSTS];
   int                  num_bursts;
   int                  errors;
   logic [WIDE_W-1:0]   exp_data [$];
   logic [WIDE_W/8-1:0] exp_strb [$];
   logic                exp_last [$];
   int                  exp_burst [$];
   // Bursts whose last wide beat has gone out and now owe a response
   int                  b_todo [$];

   axi_write_upsizer #(
      .INFO_DEPTH ( INFO_DEPTH )
   ) UUT (
      .clk_i        ( clk_i        ),
      .rst_ni       ( rst_ni       ),
      .s_aw_valid_i ( s_aw_valid_i ),
      .s_aw_addr_i  ( s_aw_addr_i  ),
      .s_aw_id_i    ( s_aw_id_i    ),
      .s_aw_len_i   ( s_aw_len_i   ),
      .s_aw_burst_i ( s_aw_burst_i ),
      .s_aw_ready_o ( s_aw_ready_o ),
      .s_w_valid_i  ( s_w_valid_i  ),
      .s_w_data_i   ( s_w_data_i   ),
      .s_w_strb_i   ( s_w_strb_i   ),
      .s_w_last_i   ( s_w_last_i   ),
      .s_w_ready_o  ( s_w_ready_o  ),
      .s_b_valid_o  ( s_b_valid_o  ),
      .s_b_id_o     ( s_b_id_o     ),
      .s_b_resp_o   ( s_b_resp_o   ),
      .s_b_ready_i  ( s_b_ready_i  ),
      .m_aw_valid_o ( m_aw_valid_o ),
      .m_aw_addr_o  ( m_aw_addr_o  ),
      .m_aw_id_o    ( m_aw_id_o    ),
      .m_aw_len_o   ( m_aw_len_o   ),
      .m_aw_size_o  ( m_aw_size_o  ),
      .m_aw_burst_o ( m_aw_burst_o ),
      .m_aw_ready_i ( m_aw_ready_i ),
      .m_w_valid_o  ( m_w_valid_o  ),
      .m_w_data_o   ( m_w_data_o   ),
      .m_w_strb_o   ( m_w_strb_o   ),
      .m_w_last_o   ( m_w_last_o   ),
      .m_w_ready_i  ( m_w_ready_i  ),
      .m_b_valid_i  ( m_b_valid_i  ),
      .m_b_id_i     ( m_b_id_i     ),
      .m_b_resp_i   ( m_b_resp_i   ),
      .m_b_ready_o  ( m_b_ready_o  )
   );

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   function automatic logic [31:0] burst_field(input int b, input int k);
      return vec_mem[b*FIELDS + k];
   endfunction

   task automatic stop_with_failure();
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped on a failed check");
   endtask

   task automatic report_mismatch(input string name, input logic [WIDE_W-1:0] got,
                                  input logic [WIDE_W-1:0] exp);
      errors++;
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_with_failure();
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("Timed out at %0t ns while waiting for %s", $time, what);
      stop_with_failure();
   endtask

   task automatic check_idle_outputs();
      assert (!m_aw_valid_o) else report_mismatch("m_aw_valid_o", m_aw_valid_o, 0);
      assert (!m_w_valid_o) else report_mismatch("m_w_valid_o", m_w_valid_o, 0);
      assert (!s_b_valid_o) else report_mismatch("s_b_valid_o", s_b_valid_o, 0);
   endtask

   task automatic load_bursts();
      $readmemh("verif/upsizer_input.txt", vec_mem);
      num_bursts = 0;
      while (num_bursts < MAX_BURSTS && !$isunknown(vec_mem[num_bursts*FIELDS]))
      begin
         num_bursts++;
      end
      assert (num_bursts > 0)
      else
      begin
         errors++;
         $display("No bursts could be read from the stimulus file");
         stop_with_failure();
      end
   endtask

   // Lanes fill upward from the start lane
   // A full top lane or the narrow last beat closes a wide beat
   // Unused lanes stay zero
   task automatic build_expected();
      logic [WIDE_W-1:0]   data;
      logic [WIDE_W/8-1:0] strb;
      int                  lane;
      int                  len;
      for (int b = 0; b < num_bursts; b++)
      begin
         lane = (burst_field(b, F_ADDR) >> NARROW_OFFSET) % RATIO;
         len  = burst_field(b, F_LEN);
         data = '0;
         strb = '0;
         for (int i = 0; i <= len; i++)
         begin
            data[lane*NARROW_W +: NARROW_W]       = NARROW_W'(burst_field(b, F_DATA) + i);
            strb[lane*(NARROW_W/8) +: NARROW_W/8] = '1;
            if (lane == RATIO - 1 || i == len)
            begin
               exp_data.push_back(data);
               exp_strb.push_back(strb);
               exp_last.push_back(i == len);
               exp_burst.push_back(b);
               data = '0;
               strb = '0;
            end
            lane = (lane + 1) % RATIO;
         end
      end
   endtask

   task automatic drive_aw();
      int waited;
      for (int b = 0; b < num_bursts; b++)
      begin
         @(negedge clk_i);
         s_aw_valid_i = 1'b1;
         s_aw_addr_i  = burst_field(b, F_ADDR);
         s_aw_id_i    = ID_W'(burst_field(b, F_ID));
         s_aw_len_i   = 8'(burst_field(b, F_LEN));
         s_aw_burst_i = 2'b01;
         waited = 0;
         @(posedge clk_i);
         while (!s_aw_ready_o)
         begin
            waited++;
            if (waited > TIMEOUT)
               report_timeout("s_aw_ready_o");
            @(posedge clk_i);
         end
      end
      @(negedge clk_i);
      s_aw_valid_i = 1'b0;
   endtask

   task automatic drive_w();
      int waited;
      int len;
      for (int b = 0; b < num_bursts; b++)
      begin
         len = burst_field(b, F_LEN);
         for (int i = 0; i <= len; i++)
         begin
            @(negedge clk_i);
            s_w_valid_i = 1'b0;
            // Occasional idle cycle between narrow beats
            if ($urandom % 4 == 0)
            begin
               @(negedge clk_i);
            end
            s_w_valid_i = 1'b1;
            s_w_data_i  = NARROW_W'(burst_field(b, F_DATA) + i);
            s_w_strb_i  = '1;
            s_w_last_i  = (i == len);
            waited = 0;
            @(posedge clk_i);
            while (!s_w_ready_o)
            begin
               waited++;
               if (waited > TIMEOUT)
                  report_timeout("s_w_ready_o");
               @(posedge clk_i);
            end
         end
      end
      @(negedge clk_i);
      s_w_valid_i = 1'b0;
      s_w_last_i  = 1'b0;
   endtask

   task automatic master_aw_model();
      int idx;
      int idle;
      idx  = 0;
      idle = 0;
      while (idx < num_bursts)
      begin
         @(negedge clk_i);
         m_aw_ready_i = ($urandom % 4) != 0;
         @(posedge clk_i);
         if (m_aw_valid_o && m_aw_ready_i)
         begin
            assert (m_aw_addr_o == burst_field(idx, F_ADDR))
               else report_mismatch("m_aw_addr_o", m_aw_addr_o, burst_field(idx, F_ADDR));
            assert (m_aw_id_o == ID_W'(burst_field(idx, F_ID)))
               else report_mismatch("m_aw_id_o", m_aw_id_o, burst_field(idx, F_ID));
            assert (m_aw_len_o == 8'(burst_field(idx, F_WLEN)))
               else report_mismatch("m_aw_len_o", m_aw_len_o, burst_field(idx, F_WLEN));
            assert (m_aw_size_o == EXP_WIDE_SIZE)
               else report_mismatch("m_aw_size_o", m_aw_size_o, EXP_WIDE_SIZE);
            assert (m_aw_burst_o == 2'b01)
               else report_mismatch("m_aw_burst_o", m_aw_burst_o, 2'b01);
            idx++;
            idle = 0;
         end
         else
         begin
            idle++;
            if (idle > TIMEOUT)
               report_timeout("a master AW transfer");
         end
      end
      @(negedge clk_i);
      m_aw_ready_i = 1'b0;
   endtask

   task automatic master_w_model();
      int idle;
      int beats;
      int b;
      idle  = 0;
      beats = 0;
      while (exp_data.size() > 0)
      begin
         @(negedge clk_i);
         m_w_ready_i = ($urandom % 4) != 0;
         @(posedge clk_i);
         if (m_w_valid_o && m_w_ready_i)
         begin
            idle = 0;
            beats++;
            b = exp_burst.pop_front();
            assert (m_w_data_o == exp_data[0])
               else report_mismatch("m_w_data_o", m_w_data_o, exp_data[0]);
            assert (m_w_strb_o == exp_strb[0])
               else report_mismatch("m_w_strb_o", m_w_strb_o, exp_strb[0]);
            assert (m_w_last_o == exp_last[0])
               else report_mismatch("m_w_last_o", m_w_last_o, exp_last[0]);
            void'(exp_data.pop_front());
            void'(exp_strb.pop_front());
            void'(exp_last.pop_front());
            if (m_w_last_o)
            begin
               assert (beats == int'(burst_field(b, F_WLEN)) + 1)
                  else report_mismatch("wide beat count", beats, burst_field(b, F_WLEN) + 1);
               beats = 0;
               b_todo.push_back(b);
            end
         end
         else
         begin
            idle++;
            if (idle > TIMEOUT)
               report_timeout("a master W beat");
         end
      end
      @(negedge clk_i);
      m_w_ready_i = 1'b0;
   endtask

   task automatic master_b_model();
      int sent;
      int idle;
      int b;
      logic taken;
      sent  = 0;
      idle  = 0;
      taken = 1'b0;
      while (sent < num_bursts)
      begin
         @(negedge clk_i);
         if (taken)
         begin
            m_b_valid_i = 1'b0;
            taken       = 1'b0;
         end
         if (!m_b_valid_i && b_todo.size() > 0)
         begin
            b = b_todo.pop_front();
            m_b_id_i    = ID_W'(burst_field(b, F_ID));
            m_b_resp_i  = 2'(burst_field(b, F_RESP));
            m_b_valid_i = 1'b1;
         end
         @(posedge clk_i);
         if (m_b_valid_i && m_b_ready_o)
         begin
            sent++;
            taken = 1'b1;
            idle  = 0;
         end
         else
         begin
            idle++;
            if (idle > TIMEOUT)
               report_timeout("a master B transfer");
         end
      end
      @(negedge clk_i);
      m_b_valid_i = 1'b0;
   endtask

   task automatic check_slave_b();
      int idx;
      int idle;
      idx  = 0;
      idle = 0;
      while (idx < num_bursts)
      begin
         @(negedge clk_i);
         s_b_ready_i = ($urandom % 3) != 0;
         @(posedge clk_i);
         if (s_b_valid_o && s_b_ready_i)
         begin
            assert (s_b_id_o == ID_W'(burst_field(idx, F_ID)))
               else report_mismatch("s_b_id_o", s_b_id_o, burst_field(idx, F_ID));
            assert (s_b_resp_o == 2'(burst_field(idx, F_RESP)))
               else report_mismatch("s_b_resp_o", s_b_resp_o, burst_field(idx, F_RESP));
            idx++;
            idle = 0;
         end
         else
         begin
            idle++;
            if (idle > TIMEOUT)
               report_timeout("a slave B response");
         end
      end
   endtask

   initial
   begin
      rst_ni       = 1'b0;
      s_aw_valid_i = 1'b0;
      s_aw_addr_i  = '0;
      s_aw_id_i    = '0;
      s_aw_len_i   = '0;
      s_aw_burst_i = 2'b01;
      s_w_valid_i  = 1'b0;
      s_w_data_i   = '0;
      s_w_strb_i   = '0;
      s_w_last_i   = 1'b0;
      s_b_ready_i  = 1'b0;
      m_aw_ready_i = 1'b0;
      m_w_ready_i  = 1'b0;
      m_b_valid_i  = 1'b0;
      m_b_id_i     = '0;
      m_b_resp_i   = '0;
      errors       = 0;
      void'($urandom(RAND_SEED));
      load_bursts();
      build_expected();

      // Outputs are sampled mid-cycle, well after the reset has settled
      repeat (5)
      begin
         @(negedge clk_i);
         check_idle_outputs();
      end
      rst_ni = 1'b1;
      @(negedge clk_i);
      check_idle_outputs();
      assert (s_aw_ready_o) else report_mismatch("s_aw_ready_o", s_aw_ready_o, 1);
      assert (!s_w_ready_o) else report_mismatch("s_w_ready_o", s_w_ready_o, 0);

      // Address and data run independently so AWs can get ahead of W
      fork
         drive_aw();
         drive_w();
         master_aw_model();
         master_w_model();
         master_b_model();
         check_slave_b();
      join

      if (errors == 0)
      begin
         $display("STATUS: PASS");
         $finish;
      end
      else
      begin
         stop_with_failure();
      end
   end

endmodule

//--- flist.f
hdl/upsize_pkg.sv
hdl/axi_reg_slice.sv
hdl/upsize_info_fifo.sv
hdl/upsize_aw_path.sv
hdl/upsize_w_packer.sv
hdl/axi_write_upsizer.sv
verif/tb_axi_write_upsizer.sv

//--- verif/upsizer_input.txt
// id  addr      len  first_data  wide_len  resp   (all hex, one INCR burst per line)
// len is the narrow AXI length, wide_len the expected master AW length
1 00001004 00 a0000000 00 0
2 00002008 05 b0000010 01 0
3 0000300c 00 c0000020 00 2
4 00004000 03 d0000030 00 0
5 00005004 0e e0000040 03 1
6 0000600c 08 f0000050 02 0
7 00007010 07 11110000 01 3
0 00008ff8 01 22220000 00 0
1 00009004 1f 33330000 08 0
2 0000a008 02 44440000 01 2
3 0000b000 00 55550000 00 0
